// ==== logic/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

	localparam int xlen    = 64;
	localparam int shamt_w = 6; // log2(xlen)

	typedef logic [xlen-1:0]    word_t;
	typedef logic [shamt_w-1:0] shamt_t;
	typedef logic [1:0]         alu_class_t;

	// operation class, from the main decoder
	localparam alu_class_t class_mem    = 2'b00; // load/store address, add
	localparam alu_class_t class_branch = 2'b01; // compare, sub
	localparam alu_class_t class_reg    = 2'b10; // register-register
	localparam alu_class_t class_imm    = 2'b11; // register-immediate

	// funct3 encodings shared by op and op-imm
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		op_xor  = 4'd4,
		op_slt  = 4'd5,
		op_sltu = 4'd6,
		op_sll  = 4'd7,
		op_srl  = 4'd8,
		op_sra  = 4'd9
	} alu_op_e;

	typedef struct packed {
		word_t      op_a;
		word_t      op_b; // immediate already placed here
		alu_class_t op_class;
		logic [2:0] funct3;
		logic       funct7_b5;
	} alu_req_t;

	typedef struct packed {
		word_t result;
		logic  zero;
		logic  carry;
		logic  less;
		logic  overflow;
	} alu_rsp_t;

endpackage

`default_nettype wire

// ==== logic/alu_decode.sv ====
`default_nettype none

module alu_decode (
	input  alu_pkg::alu_class_t op_class,
	input  logic [2:0]          funct3,
	input  logic                funct7_b5,
	output alu_pkg::alu_op_e    op
);

	import alu_pkg::*;

	logic sub_sel; // funct7 bit 5 means sub only for register ops

	assign sub_sel = (op_class == class_reg) && funct7_b5;

	always_comb begin
		op = op_add;
		case (op_class)
			class_mem: begin
				op = op_add; // address generation
			end
			class_branch: begin
				op = op_sub; // branch compare
			end
			class_reg, class_imm: begin
				case (funct3)
					f3_add_sub: begin
						op = sub_sel ? op_sub : op_add; // addi has no sub form
					end
					f3_sll: begin
						op = op_sll;
					end
					f3_slt: begin
						op = op_slt;
					end
					f3_sltu: begin
						op = op_sltu;
					end
					f3_xor: begin
						op = op_xor;
					end
					f3_srl_sra: begin
						op = funct7_b5 ? op_sra : op_srl; // srai keeps bit 30 too
					end
					f3_or: begin
						op = op_or;
					end
					f3_and: begin
						op = op_and;
					end
					default: begin
						op = op_add;
					end
				endcase
			end
			default: begin
				op = op_add;
			end
		endcase

		// encoding leaves six spare codes, none of which may reach the units
		assert (op inside {op_add, op_sub, op_and, op_or, op_xor,
			op_slt, op_sltu, op_sll, op_srl, op_sra})
		else $error("alu_decode: illegal operation %0d", op);
	end

endmodule

`default_nettype wire

// ==== logic/alu_arith.sv ====
`default_nettype none

module alu_arith (
	input  alu_pkg::alu_op_e op,
	input  alu_pkg::word_t   op_a,
	input  alu_pkg::word_t   op_b,
	output alu_pkg::word_t   sum,
	output logic             carry,
	output logic             overflow,
	output logic             zero,
	output logic             less
);

	import alu_pkg::*;

	logic  sub_mode; // a + ~b + 1
	word_t b_in;
	word_t add_out;
	logic  less_signed;
	logic  less_unsigned;
	logic  set_less; // slt or sltu

	assign sub_mode = (op != op_add);
	assign b_in     = sub_mode ? ~op_b : op_b;

	// single adder shared by add, sub and the compares
	assign {carry, add_out} = {1'b0, op_a} + {1'b0, b_in} + {{xlen{1'b0}}, sub_mode};

	// operands agree in sign but the sum does not
	assign overflow = (op_a[xlen-1] == b_in[xlen-1]) && (add_out[xlen-1] != op_a[xlen-1]);
	assign zero     = ~(|add_out);

	assign less_signed   = add_out[xlen-1] ^ overflow;
	assign less_unsigned = ~carry; // borrow out of a - b
	assign less          = (op == op_sltu) ? less_unsigned : less_signed;

	assign set_less = (op == op_slt) || (op == op_sltu);
	assign sum      = set_less ? {{(xlen-1){1'b0}}, less} : add_out;

endmodule

`default_nettype wire

// ==== logic/alu_bitshift.sv ====
`default_nettype none

module alu_bitshift (
	input  alu_pkg::alu_op_e op,
	input  alu_pkg::word_t   op_a,
	input  alu_pkg::word_t   op_b,
	output alu_pkg::word_t   result
);

	import alu_pkg::*;

	shamt_t              shamt;
	logic                fill; // sign bit for sra, else zero
	logic [2*xlen-1:0]   dbl_right;
	logic [2*xlen-1:0]   dbl_left;
	word_t               shift_right;
	word_t               shift_left;

	// only the low bits of op_b count as the shift amount
	assign shamt = op_b[shamt_w-1:0];
	assign fill  = (op == op_sra) & op_a[xlen-1];

	// doubled word, the window slides over it
	assign dbl_right = {{xlen{fill}}, op_a};
	assign dbl_left  = {op_a, {xlen{1'b0}}};

	assign shift_right = dbl_right[int'(shamt) +: xlen];
	assign shift_left  = dbl_left[(xlen - int'(shamt)) +: xlen];

	always_comb begin
		case (op)
			op_and: begin
				result = op_a & op_b;
			end
			op_or: begin
				result = op_a | op_b;
			end
			op_xor: begin
				result = op_a ^ op_b;
			end
			op_sll: begin
				result = shift_left;
			end
			op_srl, op_sra: begin
				result = shift_right; // fill picks logical or arithmetic
			end
			default: begin
				result = '0; // arithmetic op, unit idle
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/alu_result_stage.sv ====
`default_nettype none

module alu_result_stage (
	input  logic             clk,
	input  logic             reset,
	input  logic             req,
	output logic             ack,
	input  alu_pkg::alu_op_e op,
	input  alu_pkg::word_t   arith_word,
	input  logic             carry,
	input  logic             overflow,
	input  logic             zero,
	input  logic             less,
	input  alu_pkg::word_t   bit_word,
	output alu_pkg::alu_rsp_t rsp
);

	import alu_pkg::*;

	typedef enum logic [1:0] {
		st_idle    = 2'd0,
		st_busy    = 2'd1, // ack high, waiting for req to drop
		st_release = 2'd2  // ack low, idle again next cycle
	} stage_state_e;

	stage_state_e state_q;
	stage_state_e state_d;
	alu_rsp_t     rsp_q;
	alu_rsp_t     rsp_next;
	logic         use_bit; // result comes from the bitwise unit
	logic         accept;

	assign use_bit = op inside {op_and, op_or, op_xor, op_sll, op_srl, op_sra};

	always_comb begin
		rsp_next.result   = use_bit ? bit_word : arith_word;
		rsp_next.zero     = zero;
		rsp_next.carry    = carry;
		rsp_next.less     = less;
		rsp_next.overflow = overflow;
	end

	assign accept = req && !ack && (state_q == st_idle);

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (accept) begin
					state_d = st_busy;
				end
			end
			st_busy: begin
				if (!req) begin
					state_d = st_release; // requester has seen ack
				end
			end
			st_release: begin
				state_d = st_idle;
			end
			default: begin
				state_d = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= st_idle;
			rsp_q   <= '0;
		end else begin
			state_q <= state_d;
			if (accept) begin
				rsp_q <= rsp_next; // held until the next accept
			end
		end
	end

	assign ack = (state_q == st_busy);
	assign rsp = rsp_q;

	// ack only answers a sampled request
	assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req))
	else $error("alu_result_stage: ack rose without req");

	// requester reads rsp any time during ack
	assert property (@(posedge clk) disable iff (reset) ack && $past(ack) |-> $stable(rsp))
	else $error("alu_result_stage: response changed while ack high");

endmodule

`default_nettype wire

// ==== logic/alu_exec_top.sv ====
`default_nettype none

module alu_exec_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              req,
	output logic              ack,
	input  alu_pkg::alu_req_t request,
	output alu_pkg::alu_rsp_t response
);

	import alu_pkg::*;

	alu_op_e op;
	word_t   arith_word;
	word_t   bit_word;
	logic    carry;
	logic    overflow;
	logic    zero;
	logic    less;

	alu_decode u_decode (
		.op_class  (request.op_class),
		.funct3    (request.funct3),
		.funct7_b5 (request.funct7_b5),
		.op        (op)
	);

	alu_arith u_arith (
		.op       (op),
		.op_a     (request.op_a),
		.op_b     (request.op_b),
		.sum      (arith_word),
		.carry    (carry),
		.overflow (overflow),
		.zero     (zero),
		.less     (less)
	);

	alu_bitshift u_bitshift (
		.op     (op),
		.op_a   (request.op_a),
		.op_b   (request.op_b),
		.result (bit_word)
	);

	alu_result_stage u_result (
		.clk        (clk),
		.reset      (reset),
		.req        (req),
		.ack        (ack),
		.op         (op),
		.arith_word (arith_word),
		.carry      (carry),
		.overflow   (overflow),
		.zero       (zero),
		.less       (less),
		.bit_word   (bit_word),
		.rsp        (response)
	);

endmodule

`default_nettype wire

// ==== tb/alu_tb_vectors.svh ====
`ifndef ALU_TB_VECTORS_SVH
`define ALU_TB_VECTORS_SVH

// columns: op_class, funct3, funct7_b5, op_a, op_b, expected result
// flags are predicted by the reference model, not listed here
typedef struct packed {
	alu_class_t op_class;
	logic [2:0] funct3;
	logic       funct7_b5;
	word_t      op_a;
	word_t      op_b;
	word_t      exp_result;
} vector_t;

localparam int num_vectors = 34;

localparam vector_t vectors [num_vectors] = '{
	'{class_reg, 3'b000, 1'b0, 64'h0, 64'h0, 64'h0},
	'{class_reg, 3'b000, 1'b0, 64'hffffffff_ffffffff, 64'h1, 64'h0}, // carry out, zero
	'{class_reg, 3'b000, 1'b0, 64'h7fffffff_ffffffff, 64'h1, 64'h80000000_00000000},
	'{class_reg, 3'b000, 1'b1, 64'h80000000_00000000, 64'h1, 64'h7fffffff_ffffffff},
	'{class_reg, 3'b000, 1'b1, 64'h0, 64'hffffffff_ffffffff, 64'h1},
	'{class_reg, 3'b000, 1'b1, 64'h80000000_00000000, 64'h80000000_00000000, 64'h0},
	'{class_reg, 3'b000, 1'b1, 64'h7fffffff_ffffffff, 64'hffffffff_ffffffff,
		64'h80000000_00000000},
	'{class_mem, 3'b111, 1'b1, 64'h10, 64'h20, 64'h30}, // funct fields ignored
	'{class_branch, 3'b000, 1'b0, 64'h5, 64'h7, 64'hffffffff_fffffffe},
	'{class_branch, 3'b101, 1'b1, 64'h7, 64'h7, 64'h0},
	'{class_reg, 3'b010, 1'b0, 64'hffffffff_ffffffff, 64'h1, 64'h1}, // slt -1 < 1
	'{class_reg, 3'b011, 1'b0, 64'hffffffff_ffffffff, 64'h1, 64'h0}, // sltu max > 1
	'{class_reg, 3'b010, 1'b0, 64'h1, 64'h80000000_00000000, 64'h0},
	'{class_reg, 3'b011, 1'b0, 64'h1, 64'h80000000_00000000, 64'h1},
	'{class_reg, 3'b010, 1'b0, 64'h7fffffff_ffffffff, 64'h7fffffff_ffffffff, 64'h0},
	'{class_reg, 3'b111, 1'b0, 64'hf0f0f0f0_f0f0f0f0, 64'hff00ff00_ff00ff00,
		64'hf000f000_f000f000},
	'{class_reg, 3'b110, 1'b0, 64'hf0f0f0f0_f0f0f0f0, 64'hff00ff00_ff00ff00,
		64'hfff0fff0_fff0fff0},
	'{class_reg, 3'b100, 1'b0, 64'hf0f0f0f0_f0f0f0f0, 64'hff00ff00_ff00ff00,
		64'h0ff00ff0_0ff00ff0},
	'{class_reg, 3'b001, 1'b0, 64'h80000000_00000001, 64'h0, 64'h80000000_00000001},
	'{class_reg, 3'b001, 1'b0, 64'h80000000_00000001, 64'h1, 64'h2},
	'{class_reg, 3'b001, 1'b0, 64'h1, 64'h3f, 64'h80000000_00000000},
	'{class_reg, 3'b101, 1'b0, 64'h80000000_00000000, 64'h1, 64'h40000000_00000000},
	'{class_reg, 3'b101, 1'b1, 64'h80000000_00000000, 64'h1, 64'hc0000000_00000000},
	'{class_reg, 3'b101, 1'b1, 64'h80000000_00000000, 64'h3f, 64'hffffffff_ffffffff},
	'{class_reg, 3'b101, 1'b0, 64'h80000000_00000000, 64'h3f, 64'h1},
	'{class_reg, 3'b101, 1'b0, 64'hffffffff_ffffffff, 64'hffffffff_ffffff44, // shamt 4
		64'h0fffffff_ffffffff},
	'{class_reg, 3'b001, 1'b0, 64'h1, 64'hffffffff_ffffffc8, 64'h100}, // shamt 8
	'{class_reg, 3'b101, 1'b1, 64'hf0000000_00000000, 64'h104, 64'hff000000_00000000},
	'{class_reg, 3'b101, 1'b1, 64'h80000000_00000000, 64'h0, 64'h80000000_00000000},
	'{class_imm, 3'b000, 1'b1, 64'h100, 64'h23, 64'h123}, // addi, bit 5 ignored
	'{class_imm, 3'b101, 1'b1, 64'h80000000_00000010, 64'h4, 64'hf8000000_00000001},
	'{class_imm, 3'b101, 1'b0, 64'h80000000_00000010, 64'h4, 64'h08000000_00000001},
	'{class_imm, 3'b010, 1'b0, 64'hffffffff_fffffffb, 64'hffffffff_fffffffc, 64'h1},
	'{class_imm, 3'b011, 1'b1, 64'hffffffff_fffffffb, 64'hffffffff_fffffffc, 64'h1}
};

`endif

// ==== tb/alu_tb.sv ====
`default_nettype none

module alu_tb;

	import alu_pkg::*;

	`include "alu_tb_vectors.svh"

	localparam int wait_limit   = 20; // cycles before a handshake wait gives up
	localparam int random_count = 400;

	logic     clk;
	logic     reset;
	logic     req;
	logic     ack;
	alu_req_t request;
	alu_rsp_t response;
	alu_req_t stim;
	alu_rsp_t got;
	alu_rsp_t expect_rsp;
	int       error_count;
	int       timeout_count;

	alu_exec_top i_dut (
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.ack      (ack),
		.request  (request),
		.response (response)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_flags(input string tag, input alu_rsp_t exp_rsp, input alu_rsp_t act);
		check_value({tag, ".zero"}, 64'(exp_rsp.zero), 64'(act.zero));
		check_value({tag, ".carry"}, 64'(exp_rsp.carry), 64'(act.carry));
		check_value({tag, ".less"}, 64'(exp_rsp.less), 64'(act.less));
		check_value({tag, ".overflow"}, 64'(exp_rsp.overflow), 64'(act.overflow));
	endtask

	// operation decode for the reference model
	function automatic alu_op_e decode_fields(input alu_class_t cls, input logic [2:0] f3,
		input logic f7);
		alu_op_e op;
		op = op_add;
		if (cls == class_branch) begin
			op = op_sub;
		end else if (cls == class_reg || cls == class_imm) begin
			case (f3)
				3'b000: op = (cls == class_reg && f7) ? op_sub : op_add;
				3'b001: op = op_sll;
				3'b010: op = op_slt;
				3'b011: op = op_sltu;
				3'b100: op = op_xor;
				3'b101: op = f7 ? op_sra : op_srl;
				3'b110: op = op_or;
				default: op = op_and;
			endcase
		end
		return op;
	endfunction

	function automatic alu_rsp_t predict_response(input alu_req_t r);
		alu_op_e       op;
		word_t         b_eff;
		logic          cin;
		logic [xlen:0] usum; // zero extended, bit xlen is carry out
		logic [xlen:0] ssum; // sign extended, exact signed result
		shamt_t        sh;
		alu_rsp_t      p;
		op    = decode_fields(r.op_class, r.funct3, r.funct7_b5);
		b_eff = (op == op_add) ? r.op_b : ~r.op_b;
		cin   = (op != op_add);
		usum  = {1'b0, r.op_a} + {1'b0, b_eff} + {{xlen{1'b0}}, cin};
		ssum  = {r.op_a[xlen-1], r.op_a} + {b_eff[xlen-1], b_eff} + {{xlen{1'b0}}, cin};
		sh    = r.op_b[shamt_w-1:0];
		p.carry    = usum[xlen];
		p.overflow = ssum[xlen] ^ ssum[xlen-1]; // true sign lost in 64 bits
		p.zero     = (usum[xlen-1:0] == '0);
		p.less     = (op == op_sltu) ? (r.op_a < r.op_b) : ssum[xlen];
		case (op)
			op_and:  p.result = r.op_a & r.op_b;
			op_or:   p.result = r.op_a | r.op_b;
			op_xor:  p.result = r.op_a ^ r.op_b;
			op_slt:  p.result = ($signed(r.op_a) < $signed(r.op_b)) ? 64'd1 : 64'd0;
			op_sltu: p.result = (r.op_a < r.op_b) ? 64'd1 : 64'd0;
			op_sll:  p.result = r.op_a << sh;
			op_srl:  p.result = r.op_a >> sh;
			op_sra:  p.result = $signed(r.op_a) >>> sh;
			default: p.result = usum[xlen-1:0];
		endcase
		return p;
	endfunction

	// full four-phase cycle, req held extra_hold cycles past ack
	task automatic run_transaction(input alu_req_t r, input int extra_hold,
		output alu_rsp_t sampled);
		int cycles;
		@(negedge clk);
		request = r;
		req     = 1'b1;
		cycles  = 0;
		while (ack !== 1'b1 && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		sampled = response;
		if (ack !== 1'b1) begin
			timeout_count++;
			$display("Timeout: ack did not rise within %0d cycles of req", wait_limit);
		end else begin
			check_value("ack_rise_cycles", 64'd1, 64'(cycles));
			repeat (extra_hold) begin
				@(negedge clk);
				check_value("ack", 64'd1, 64'(ack));
				check_value("response.result", sampled.result, response.result);
				check_flags("response", sampled, response);
			end
		end
		req    = 1'b0;
		cycles = 0;
		while (ack !== 1'b0 && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (ack !== 1'b0) begin
			timeout_count++;
			$display("Timeout: ack did not fall within %0d cycles of req dropping", wait_limit);
		end else begin
			check_value("ack_fall_cycles", 64'd1, 64'(cycles));
		end
	endtask

	initial begin
		void'($urandom(31));
		error_count   = 0;
		timeout_count = 0;
		reset   = 1'b1;
		req     = 1'b0;
		request = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_value("ack", 64'd0, 64'(ack));
		check_value("response.result", 64'd0, response.result);
		check_flags("response", '0, response);

		for (int i = 0; i < num_vectors; i++) begin
			stim.op_class  = vectors[i].op_class;
			stim.funct3    = vectors[i].funct3;
			stim.funct7_b5 = vectors[i].funct7_b5;
			stim.op_a      = vectors[i].op_a;
			stim.op_b      = vectors[i].op_b;
			expect_rsp     = predict_response(stim);
			run_transaction(stim, 0, got);
			check_value($sformatf("vec%0d.result", i), vectors[i].exp_result, got.result);
			check_flags($sformatf("vec%0d", i), expect_rsp, got);
		end

		// slow requester keeps the stage busy
		stim = '{op_a: 64'h1234, op_b: 64'h5678, op_class: class_reg, funct3: 3'b000,
			funct7_b5: 1'b1};
		expect_rsp = predict_response(stim);
		run_transaction(stim, 6, got);
		check_value("hold.result", expect_rsp.result, got.result);
		check_flags("hold", expect_rsp, got);

		for (int n = 0; n < random_count; n++) begin
			stim.op_a      = {$urandom, $urandom};
			stim.op_b      = {$urandom, $urandom};
			stim.op_class  = alu_class_t'($urandom_range(0, 3));
			stim.funct3    = 3'($urandom_range(0, 7));
			stim.funct7_b5 = 1'($urandom_range(0, 1));
			if ($urandom_range(0, 7) == 0) begin
				stim.op_b = stim.op_a; // reach the zero flag now and then
			end
			expect_rsp = predict_response(stim);
			run_transaction(stim, 0, got);
			check_value($sformatf("rand%0d.result", n), expect_rsp.result, got.result);
			check_flags($sformatf("rand%0d", n), expect_rsp, got);
		end

		$display("Summary: %0d errors, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+tb
logic/alu_pkg.sv
logic/alu_decode.sv
logic/alu_arith.sv
logic/alu_bitshift.sv
logic/alu_result_stage.sv
logic/alu_exec_top.sv
tb/alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
	--top-module alu_tb \
	-f flist.f \
	-o alu_sim

./obj_dir/alu_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "run_sim: simulation passed"
else
	echo "run_sim: simulation failed, see sim.log"
	exit 1
fi
